// File: Makefile
# Verilator flow for the trace unit

VERILATOR ?= verilator
TOP ?= tbCcipTracer
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing --assert --timescale 1ns/10ps
SIM_FLAGS ?= -Wno-fatal
PASS_MSG ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
+incdir+logic
logic/ccipPkg.sv
logic/tracePkg.sv
logic/ccipEventEncoder.sv
logic/traceFifo.sv
logic/traceReader.sv
logic/ccipTracer.sv
tb/tbCcipTracer.sv

// File: logic/ccipEventEncoder.sv
`timescale 1ns/10ps
`default_nettype none

module ccipEventEncoder (
   input logic clk,
   input logic rstN,
   input logic traceEnable,
   input logic swResetN,
   input logic cfgWrValid,
   input ccipPkg::ccipIndexT cfgIndex,
   input ccipPkg::ccipDataT cfgData,
   input logic c0TxRdValid,
   input ccipPkg::ccipVcT c0TxVc,
   input ccipPkg::ccipReqE c0TxReq,
   input ccipPkg::ccipAddrT c0TxAddr,
   input ccipPkg::ccipMdataT c0TxMdata,
   input logic c1TxWrValid,
   input ccipPkg::ccipVcT c1TxVc,
   input ccipPkg::ccipReqE c1TxReq,
   input ccipPkg::ccipAddrT c1TxAddr,
   input ccipPkg::ccipMdataT c1TxMdata,
   input ccipPkg::ccipDataT c1TxData,
   input logic c0RxRdValid,
   input ccipPkg::ccipVcT c0RxVc,
   input ccipPkg::ccipRespE c0RxResp,
   input ccipPkg::ccipMdataT c0RxMdata,
   input ccipPkg::ccipDataT c0RxData,
   input logic c1RxWrValid,
   input ccipPkg::ccipVcT c1RxVc,
   input ccipPkg::ccipRespE c1RxResp,
   input ccipPkg::ccipMdataT c1RxMdata,
   output logic recValid,
   output tracePkg::traceKindE recKind,
   output tracePkg::traceTsT recTs,
   output ccipPkg::ccipVcT recVc,
   output tracePkg::traceCodeT recCode,
   output ccipPkg::ccipAddrT recAddr,
   output ccipPkg::ccipMdataT recMdata,
   output ccipPkg::ccipDataT recData,
   output tracePkg::traceCntT lostCount
);

   import ccipPkg::*;
   import tracePkg::*;

   // Last seen software reset level
   logic swPrev;
   logic swToggle;
   traceTsT tsCnt;

   // One bit per event with bit 0 the highest priority
   logic [5:0] evVec;
   logic [2:0] evCount;

   // Selected record before the output register
   traceKindE selKind;
   ccipVcT selVc;
   traceCodeT selCode;
   ccipAddrT selAddr;
   ccipMdataT selMdata;
   ccipDataT selData;

   assign swToggle = swPrev != swResetN;

   always_comb begin
      evVec = {c1TxWrValid, c0TxRdValid, c1RxWrValid, c0RxRdValid, cfgWrValid, swToggle};
      // Nothing counts while tracing is off
      evVec = evVec & {6{traceEnable}};
      evCount = '0;
      for (int i = 0; i < 6; i++) begin
         evCount = evCount + {2'b00, evVec[i]};
      end
   end

   // Priority pick with unused fields zeroed
   always_comb begin
      selKind = kSwReset;
      selVc = VA;
      selCode = '0;
      selAddr = '0;
      selMdata = '0;
      selData = '0;
      if (evVec[0]) begin
         // Code carries the new reset level
         selCode = {3'b000, swResetN};
      end else if (evVec[1]) begin
         selKind = kCfgWr;
         selAddr = ccipAddrT'(cfgIndex);
         selData = cfgData;
      end else if (evVec[2]) begin
         selKind = kRdResp;
         selVc = c0RxVc;
         selCode = c0RxResp;
         selMdata = c0RxMdata;
         selData = c0RxData;
      end else if (evVec[3]) begin
         selKind = kWrResp;
         selVc = c1RxVc;
         selCode = c1RxResp;
         selMdata = c1RxMdata;
      end else if (evVec[4]) begin
         selKind = kRdReq;
         selVc = c0TxVc;
         selCode = c0TxReq;
         selAddr = c0TxAddr;
         selMdata = c0TxMdata;
      end else if (evVec[5]) begin
         selKind = kWrReq;
         selVc = c1TxVc;
         selCode = c1TxReq;
         selAddr = c1TxAddr;
         selMdata = c1TxMdata;
         selData = c1TxData;
      end
   end

   // Level follows swResetN in every cycle
   always_ff @(posedge clk) begin
      swPrev <= swResetN;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         recValid <= 1'b0;
         tsCnt <= '0;
         lostCount <= '0;
      end else begin
         recValid <= |evVec;
         tsCnt <= tsCnt + 1'b1;
         // All but the recorded event are lost
         if (evCount > 3'd1) begin
            lostCount <= lostCount + traceCntT'(evCount - 3'd1);
         end
      end
   end

   // Record payload
   always_ff @(posedge clk) begin
      recKind <= selKind;
      recTs <= tsCnt;
      recVc <= selVc;
      recCode <= selCode;
      recAddr <= selAddr;
      recMdata <= selMdata;
      recData <= selData;
   end

   kindLegal: assert property (@(posedge clk) disable iff (!rstN)
      recValid |-> recKind inside {kSwReset, kCfgWr, kRdResp, kWrResp, kRdReq, kWrReq});

endmodule

`default_nettype wire

// File: logic/ccipPkg.sv
`default_nettype none

`include "ccip_defs.svh"

package ccipPkg;

   // Link header fields
   typedef logic [`CCIP_ADDR_WIDTH-1:0] ccipAddrT;
   typedef logic [`CCIP_MDATA_WIDTH-1:0] ccipMdataT;
   typedef logic [`CCIP_DATA_WIDTH-1:0] ccipDataT;
   typedef logic [`CCIP_INDEX_WIDTH-1:0] ccipIndexT;

   // Virtual channel select
   typedef enum logic [1:0] {
      VA = 2'b00,
      VL0 = 2'b01,
      VH0 = 2'b10,
      VH1 = 2'b11
   } ccipVcT;

   // Transmit request codes
   // Reads on channel 0, writes and fence on channel 1
   typedef enum logic [3:0] {
      rdLineS = 4'h4,
      rdLineI = 4'h6,
      rdLineE = 4'h7,
      wrLineI = 4'h1,
      wrLineM = 4'h2,
      wrFence = 4'h5
   } ccipReqE;

   // Receive response codes
   typedef enum logic [3:0] {
      wrResp = 4'h1,
      rdResp = 4'h4
   } ccipRespE;

endpackage

`default_nettype wire

// File: logic/ccipTracer.sv
`timescale 1ns/10ps
`default_nettype none

module ccipTracer (
   input logic clk,
   input logic rstN,
   input logic traceEnable,
   input logic swResetN,
   input logic cfgWrValid,
   input ccipPkg::ccipIndexT cfgIndex,
   input ccipPkg::ccipDataT cfgData,
   input logic c0TxRdValid,
   input ccipPkg::ccipVcT c0TxVc,
   input ccipPkg::ccipReqE c0TxReq,
   input ccipPkg::ccipAddrT c0TxAddr,
   input ccipPkg::ccipMdataT c0TxMdata,
   input logic c1TxWrValid,
   input ccipPkg::ccipVcT c1TxVc,
   input ccipPkg::ccipReqE c1TxReq,
   input ccipPkg::ccipAddrT c1TxAddr,
   input ccipPkg::ccipMdataT c1TxMdata,
   input ccipPkg::ccipDataT c1TxData,
   input logic c0RxRdValid,
   input ccipPkg::ccipVcT c0RxVc,
   input ccipPkg::ccipRespE c0RxResp,
   input ccipPkg::ccipMdataT c0RxMdata,
   input ccipPkg::ccipDataT c0RxData,
   input logic c1RxWrValid,
   input ccipPkg::ccipVcT c1RxVc,
   input ccipPkg::ccipRespE c1RxResp,
   input ccipPkg::ccipMdataT c1RxMdata,
   input logic rdStrobe,
   output logic rdValid,
   output logic rdEmpty,
   output tracePkg::traceKindE rdKind,
   output tracePkg::traceTsT rdTs,
   output ccipPkg::ccipVcT rdVc,
   output tracePkg::traceCodeT rdCode,
   output ccipPkg::ccipAddrT rdAddr,
   output ccipPkg::ccipMdataT rdMdata,
   output ccipPkg::ccipDataT rdData,
   output tracePkg::traceCntT lostCount,
   output tracePkg::traceCntT dropCount
);

   import ccipPkg::*;
   import tracePkg::*;

   // Encoder to FIFO
   logic recValid;
   traceKindE recKind;
   traceTsT recTs;
   ccipVcT recVc;
   traceCodeT recCode;
   ccipAddrT recAddr;
   ccipMdataT recMdata;
   ccipDataT recData;

   // FIFO head to reader
   logic fifoEmpty;
   logic popStrobe;
   traceKindE headKind;
   traceTsT headTs;
   ccipVcT headVc;
   traceCodeT headCode;
   ccipAddrT headAddr;
   ccipMdataT headMdata;
   ccipDataT headData;

   ccipEventEncoder encoder0 (
      .clk(clk), .rstN(rstN), .traceEnable(traceEnable), .swResetN(swResetN),
      .cfgWrValid(cfgWrValid), .cfgIndex(cfgIndex), .cfgData(cfgData),
      .c0TxRdValid(c0TxRdValid), .c0TxVc(c0TxVc), .c0TxReq(c0TxReq),
      .c0TxAddr(c0TxAddr), .c0TxMdata(c0TxMdata),
      .c1TxWrValid(c1TxWrValid), .c1TxVc(c1TxVc), .c1TxReq(c1TxReq),
      .c1TxAddr(c1TxAddr), .c1TxMdata(c1TxMdata), .c1TxData(c1TxData),
      .c0RxRdValid(c0RxRdValid), .c0RxVc(c0RxVc), .c0RxResp(c0RxResp),
      .c0RxMdata(c0RxMdata), .c0RxData(c0RxData),
      .c1RxWrValid(c1RxWrValid), .c1RxVc(c1RxVc), .c1RxResp(c1RxResp),
      .c1RxMdata(c1RxMdata),
      .recValid(recValid), .recKind(recKind), .recTs(recTs), .recVc(recVc),
      .recCode(recCode), .recAddr(recAddr), .recMdata(recMdata), .recData(recData),
      .lostCount(lostCount)
   );

   traceFifo fifo0 (
      .clk(clk), .rstN(rstN),
      .pushStrobe(recValid), .pushKind(recKind), .pushTs(recTs), .pushVc(recVc),
      .pushCode(recCode), .pushAddr(recAddr), .pushMdata(recMdata), .pushData(recData),
      .popStrobe(popStrobe), .fifoEmpty(fifoEmpty),
      .headKind(headKind), .headTs(headTs), .headVc(headVc), .headCode(headCode),
      .headAddr(headAddr), .headMdata(headMdata), .headData(headData),
      .dropCount(dropCount)
   );

   traceReader reader0 (
      .clk(clk), .rstN(rstN), .rdStrobe(rdStrobe), .fifoEmpty(fifoEmpty),
      .headKind(headKind), .headTs(headTs), .headVc(headVc), .headCode(headCode),
      .headAddr(headAddr), .headMdata(headMdata), .headData(headData),
      .popStrobe(popStrobe), .rdValid(rdValid), .rdEmpty(rdEmpty),
      .rdKind(rdKind), .rdTs(rdTs), .rdVc(rdVc), .rdCode(rdCode),
      .rdAddr(rdAddr), .rdMdata(rdMdata), .rdData(rdData)
   );

endmodule

`default_nettype wire

// File: logic/ccip_defs.svh
`ifndef CCIP_DEFS_SVH
`define CCIP_DEFS_SVH

// Cache-line address width
`define CCIP_ADDR_WIDTH 32

// Request tag, echoed back in the response
`define CCIP_MDATA_WIDTH 16

// Traced data, narrowed from the full line
`define CCIP_DATA_WIDTH 64

// Config register index
`define CCIP_INDEX_WIDTH 16

// Cycle timestamp and loss counters
`define TRACE_TS_WIDTH 32
`define TRACE_CNT_WIDTH 16

// Trace FIFO entries, power of two
`define TRACE_DEPTH 16

`endif

// File: logic/traceFifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "ccip_defs.svh"

module traceFifo (
   input logic clk,
   input logic rstN,
   input logic pushStrobe,
   input tracePkg::traceKindE pushKind,
   input tracePkg::traceTsT pushTs,
   input ccipPkg::ccipVcT pushVc,
   input tracePkg::traceCodeT pushCode,
   input ccipPkg::ccipAddrT pushAddr,
   input ccipPkg::ccipMdataT pushMdata,
   input ccipPkg::ccipDataT pushData,
   input logic popStrobe,
   output logic fifoEmpty,
   output tracePkg::traceKindE headKind,
   output tracePkg::traceTsT headTs,
   output ccipPkg::ccipVcT headVc,
   output tracePkg::traceCodeT headCode,
   output ccipPkg::ccipAddrT headAddr,
   output ccipPkg::ccipMdataT headMdata,
   output ccipPkg::ccipDataT headData,
   output tracePkg::traceCntT dropCount
);

   import ccipPkg::*;
   import tracePkg::*;

   localparam int depth = `TRACE_DEPTH;
   localparam int addrW = $clog2(depth);

   // One array per record field
   traceKindE kindMem [depth];
   traceTsT tsMem [depth];
   ccipVcT vcMem [depth];
   traceCodeT codeMem [depth];
   ccipAddrT addrMem [depth];
   ccipMdataT mdataMem [depth];
   ccipDataT dataMem [depth];

   // Extra MSB tells full from empty
   logic [addrW:0] wrPtr;
   logic [addrW:0] rdPtr;
   logic [addrW:0] occupancy;
   logic fifoFull;
   logic doPop;
   logic doPush;

   assign occupancy = wrPtr - rdPtr;
   assign fifoEmpty = wrPtr == rdPtr;
   assign fifoFull = (wrPtr[addrW] != rdPtr[addrW])
      && (wrPtr[addrW-1:0] == rdPtr[addrW-1:0]);
   assign doPop = popStrobe && !fifoEmpty;
   // Same-cycle pop frees the slot first
   assign doPush = pushStrobe && (!fifoFull || doPop);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         dropCount <= '0;
      end else begin
         if (doPush) wrPtr <= wrPtr + 1'b1;
         if (doPop) rdPtr <= rdPtr + 1'b1;
         if (pushStrobe && !doPush) dropCount <= dropCount + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (doPush) begin
         kindMem[wrPtr[addrW-1:0]] <= pushKind;
         tsMem[wrPtr[addrW-1:0]] <= pushTs;
         vcMem[wrPtr[addrW-1:0]] <= pushVc;
         codeMem[wrPtr[addrW-1:0]] <= pushCode;
         addrMem[wrPtr[addrW-1:0]] <= pushAddr;
         mdataMem[wrPtr[addrW-1:0]] <= pushMdata;
         dataMem[wrPtr[addrW-1:0]] <= pushData;
      end
   end

   // Head is read without a register
   assign headKind = kindMem[rdPtr[addrW-1:0]];
   assign headTs = tsMem[rdPtr[addrW-1:0]];
   assign headVc = vcMem[rdPtr[addrW-1:0]];
   assign headCode = codeMem[rdPtr[addrW-1:0]];
   assign headAddr = addrMem[rdPtr[addrW-1:0]];
   assign headMdata = mdataMem[rdPtr[addrW-1:0]];
   assign headData = dataMem[rdPtr[addrW-1:0]];

   // Reader must check empty before it pops
   noPopEmpty: assert property (@(posedge clk) disable iff (!rstN)
      popStrobe |-> !fifoEmpty);

   noOverfill: assert property (@(posedge clk) disable iff (!rstN)
      occupancy <= depth);

endmodule

`default_nettype wire

// File: logic/tracePkg.sv
`default_nettype none

`include "ccip_defs.svh"

package tracePkg;

   // Record kinds, listed from highest priority down
   typedef enum logic [2:0] {
      kSwReset = 3'd0,
      kCfgWr = 3'd1,
      kRdResp = 3'd2,
      kWrResp = 3'd3,
      kRdReq = 3'd4,
      kWrReq = 3'd5
   } traceKindE;

   // Cycles since reset
   typedef logic [`TRACE_TS_WIDTH-1:0] traceTsT;

   // Lost and dropped record counters
   typedef logic [`TRACE_CNT_WIDTH-1:0] traceCntT;

   // Request code, response code or new reset level
   typedef logic [3:0] traceCodeT;

   // Reader FSM
   typedef enum logic {
      rsIdle = 1'b0,
      rsPresent = 1'b1
   } readerStateE;

endpackage

`default_nettype wire

// File: logic/traceReader.sv
`timescale 1ns/10ps
`default_nettype none

module traceReader (
   input logic clk,
   input logic rstN,
   input logic rdStrobe,
   input logic fifoEmpty,
   input tracePkg::traceKindE headKind,
   input tracePkg::traceTsT headTs,
   input ccipPkg::ccipVcT headVc,
   input tracePkg::traceCodeT headCode,
   input ccipPkg::ccipAddrT headAddr,
   input ccipPkg::ccipMdataT headMdata,
   input ccipPkg::ccipDataT headData,
   output logic popStrobe,
   output logic rdValid,
   output logic rdEmpty,
   output tracePkg::traceKindE rdKind,
   output tracePkg::traceTsT rdTs,
   output ccipPkg::ccipVcT rdVc,
   output tracePkg::traceCodeT rdCode,
   output ccipPkg::ccipAddrT rdAddr,
   output ccipPkg::ccipMdataT rdMdata,
   output ccipPkg::ccipDataT rdData
);

   import tracePkg::*;

   readerStateE state;

   // Pop in the same cycle as the strobe, head is latched at that edge
   assign popStrobe = rdStrobe && !fifoEmpty;
   assign rdValid = state == rsPresent;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= rsIdle;
         rdEmpty <= 1'b0;
      end else begin
         // Back-to-back strobes stay in present
         state <= popStrobe ? rsPresent : rsIdle;
         rdEmpty <= rdStrobe && fifoEmpty;
      end
   end

   // Output fields hold until the next pop
   always_ff @(posedge clk) begin
      if (popStrobe) begin
         rdKind <= headKind;
         rdTs <= headTs;
         rdVc <= headVc;
         rdCode <= headCode;
         rdAddr <= headAddr;
         rdMdata <= headMdata;
         rdData <= headData;
      end
   end

endmodule

`default_nettype wire

// File: tb/tbCcipTracer.sv
`timescale 1ns/10ps
`default_nettype none

`include "ccip_defs.svh"

module tbCcipTracer;

   import ccipPkg::*;
   import tracePkg::*;

   localparam int depth = `TRACE_DEPTH;

   // Test lengths in cycles
   localparam int gap = 4;
   localparam int idle = 3;
   localparam int bursts = 8;
   localparam int burstLen = 12;
   localparam int offLen = 24;
   localparam int fillExtra = 5;
   localparam int nToggle = 6;
   // Strobe, response and margin for retries
   localparam int readCost = 6;

   localparam int singleCyc = 6 * gap + idle + 7 * readCost;
   localparam int randCyc = bursts * (burstLen + idle + (burstLen + 1) * readCost);
   localparam int offCyc = 2 + offLen + idle + readCost;
   localparam int fillCyc = depth + fillExtra + idle + (depth + 1) * readCost;
   localparam int togCyc = nToggle * gap + idle + (nToggle + 1) * readCost;
   localparam int totalCycles = 16 + singleCyc + randCyc + offCyc + fillCyc + togCyc;

   // One expected trace record
   typedef struct packed {
      traceKindE kind;
      traceTsT ts;
      ccipVcT vc;
      traceCodeT code;
      ccipAddrT addr;
      ccipMdataT mdata;
      ccipDataT data;
   } recT;

   logic clk = 1'b0;
   logic rstN;
   logic traceEnable;
   logic swResetN;
   logic cfgWrValid;
   ccipIndexT cfgIndex;
   ccipDataT cfgData;
   logic c0TxRdValid;
   ccipVcT c0TxVc;
   ccipReqE c0TxReq;
   ccipAddrT c0TxAddr;
   ccipMdataT c0TxMdata;
   logic c1TxWrValid;
   ccipVcT c1TxVc;
   ccipReqE c1TxReq;
   ccipAddrT c1TxAddr;
   ccipMdataT c1TxMdata;
   ccipDataT c1TxData;
   logic c0RxRdValid;
   ccipVcT c0RxVc;
   ccipRespE c0RxResp;
   ccipMdataT c0RxMdata;
   ccipDataT c0RxData;
   logic c1RxWrValid;
   ccipVcT c1RxVc;
   ccipRespE c1RxResp;
   ccipMdataT c1RxMdata;
   logic rdStrobe;
   logic rdValid;
   logic rdEmpty;
   traceKindE rdKind;
   traceTsT rdTs;
   ccipVcT rdVc;
   traceCodeT rdCode;
   ccipAddrT rdAddr;
   ccipMdataT rdMdata;
   ccipDataT rdData;
   traceCntT lostCount;
   traceCntT dropCount;

   // Model state
   recT expQ[$];
   traceTsT tsModel;
   logic swPrevModel;
   int expLost = 0;
   int expDrop = 0;

   ccipTracer dut0 (
      .clk(clk), .rstN(rstN), .traceEnable(traceEnable), .swResetN(swResetN),
      .cfgWrValid(cfgWrValid), .cfgIndex(cfgIndex), .cfgData(cfgData),
      .c0TxRdValid(c0TxRdValid), .c0TxVc(c0TxVc), .c0TxReq(c0TxReq),
      .c0TxAddr(c0TxAddr), .c0TxMdata(c0TxMdata),
      .c1TxWrValid(c1TxWrValid), .c1TxVc(c1TxVc), .c1TxReq(c1TxReq),
      .c1TxAddr(c1TxAddr), .c1TxMdata(c1TxMdata), .c1TxData(c1TxData),
      .c0RxRdValid(c0RxRdValid), .c0RxVc(c0RxVc), .c0RxResp(c0RxResp),
      .c0RxMdata(c0RxMdata), .c0RxData(c0RxData),
      .c1RxWrValid(c1RxWrValid), .c1RxVc(c1RxVc), .c1RxResp(c1RxResp),
      .c1RxMdata(c1RxMdata), .rdStrobe(rdStrobe),
      .rdValid(rdValid), .rdEmpty(rdEmpty), .rdKind(rdKind), .rdTs(rdTs),
      .rdVc(rdVc), .rdCode(rdCode), .rdAddr(rdAddr), .rdMdata(rdMdata),
      .rdData(rdData), .lostCount(lostCount), .dropCount(dropCount)
   );

   always #20 clk = ~clk;

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic checkKind(input string name, input traceKindE act, input traceKindE want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkTs(input string name, input traceTsT act, input traceTsT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkVc(input string name, input ccipVcT act, input ccipVcT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkCode(input string name, input traceCodeT act, input traceCodeT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkAddr(input string name, input ccipAddrT act, input ccipAddrT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkMdata(input string name, input ccipMdataT act, input ccipMdataT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkData(input string name, input ccipDataT act, input ccipDataT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   task automatic checkCnt(input string name, input traceCntT act, input traceCntT want);
      if (act !== want) begin
         abortRun($sformatf("** Error: %s = 0x%h, expected 0x%h", name, act, want));
      end
   endtask

   // Expected record of this cycle and the number of active events
   function automatic int refEncode(output recT rec);
      logic toggle;
      logic [5:0] active;
      int n;
      rec = '0;
      rec.ts = tsModel;
      n = 0;
      if (traceEnable) begin
         toggle = swResetN != swPrevModel;
         active = {toggle, cfgWrValid, c0RxRdValid, c1RxWrValid, c0TxRdValid, c1TxWrValid};
         n = $countones(active);
         // Highest priority first
         if (toggle) begin
            rec.kind = kSwReset;
            rec.code = {3'b000, swResetN};
         end else if (cfgWrValid) begin
            rec.kind = kCfgWr;
            rec.addr = ccipAddrT'(cfgIndex);
            rec.data = cfgData;
         end else if (c0RxRdValid) begin
            rec.kind = kRdResp;
            rec.vc = c0RxVc;
            rec.code = c0RxResp;
            rec.mdata = c0RxMdata;
            rec.data = c0RxData;
         end else if (c1RxWrValid) begin
            rec.kind = kWrResp;
            rec.vc = c1RxVc;
            rec.code = c1RxResp;
            rec.mdata = c1RxMdata;
         end else if (c0TxRdValid) begin
            rec.kind = kRdReq;
            rec.vc = c0TxVc;
            rec.code = c0TxReq;
            rec.addr = c0TxAddr;
            rec.mdata = c0TxMdata;
         end else if (c1TxWrValid) begin
            rec.kind = kWrReq;
            rec.vc = c1TxVc;
            rec.code = c1TxReq;
            rec.addr = c1TxAddr;
            rec.mdata = c1TxMdata;
            rec.data = c1TxData;
         end
      end
      return n;
   endfunction

   // Model sees the same pre-edge inputs as the DUT
   always @(posedge clk) begin
      recT rec;
      int n;
      if (!rstN) begin
         tsModel = '0;
      end else begin
         n = refEncode(rec);
         if (n > 0) begin
            expLost += n - 1;
            // Full buffer drops the record
            if (expQ.size() >= depth) begin
               expDrop++;
            end else begin
               expQ.push_back(rec);
            end
         end
         tsModel = tsModel + 1;
      end
      swPrevModel = swResetN;
   end

   // Read port compare at the falling edge where outputs are stable
   always @(negedge clk) begin
      recT want;
      if (rstN && rdValid && rdEmpty) begin
         abortRun("rdValid and rdEmpty are high in the same cycle");
      end else if (rstN && rdValid) begin
         if (expQ.size() == 0) begin
            abortRun("A record was read back that the model does not expect");
         end else begin
            want = expQ.pop_front();
            checkKind("rdKind", rdKind, want.kind);
            checkTs("rdTs", rdTs, want.ts);
            checkVc("rdVc", rdVc, want.vc);
            checkCode("rdCode", rdCode, want.code);
            checkAddr("rdAddr", rdAddr, want.addr);
            checkMdata("rdMdata", rdMdata, want.mdata);
            checkData("rdData", rdData, want.data);
         end
      end
   end

   function automatic ccipReqE randRdReq();
      ccipReqE r;
      case ($urandom_range(0, 2))
         0: r = rdLineS;
         1: r = rdLineI;
         default: r = rdLineE;
      endcase
      return r;
   endfunction

   function automatic ccipReqE randWrReq();
      ccipReqE r;
      case ($urandom_range(0, 2))
         0: r = wrLineI;
         1: r = wrLineM;
         default: r = wrFence;
      endcase
      return r;
   endfunction

   // Bit 0 is a reset toggle and bits 1 to 5 are the strobes in priority order
   function automatic logic [5:0] randomMask();
      logic [5:0] m;
      m[0] = $urandom_range(0, 7) == 0;
      for (int i = 1; i < 6; i++) begin
         m[i] = $urandom_range(0, 1) == 1;
      end
      return m;
   endfunction

   // One link cycle with a fresh payload
   task automatic stepCycle(input logic [5:0] ev);
      @(posedge clk);
      if (ev[0]) begin
         swResetN <= ~swResetN;
      end
      cfgWrValid <= ev[1];
      c0RxRdValid <= ev[2];
      c1RxWrValid <= ev[3];
      c0TxRdValid <= ev[4];
      c1TxWrValid <= ev[5];
      cfgIndex <= ccipIndexT'($urandom);
      cfgData <= {$urandom, $urandom};
      c0TxVc <= ccipVcT'($urandom_range(0, 3));
      c0TxReq <= randRdReq();
      c0TxAddr <= $urandom;
      c0TxMdata <= ccipMdataT'($urandom);
      c1TxVc <= ccipVcT'($urandom_range(0, 3));
      c1TxReq <= randWrReq();
      c1TxAddr <= $urandom;
      c1TxMdata <= ccipMdataT'($urandom);
      c1TxData <= {$urandom, $urandom};
      c0RxVc <= ccipVcT'($urandom_range(0, 3));
      c0RxMdata <= ccipMdataT'($urandom);
      c0RxData <= {$urandom, $urandom};
      c1RxVc <= ccipVcT'($urandom_range(0, 3));
      c1RxMdata <= ccipMdataT'($urandom);
   endtask

   // One read strobe and a wait for either answer
   task automatic readOnce(output logic gotEmpty);
      int waitCnt;
      @(posedge clk);
      rdStrobe <= 1'b1;
      @(posedge clk);
      rdStrobe <= 1'b0;
      waitCnt = 0;
      do begin
         @(posedge clk);
         waitCnt++;
      end while (!rdValid && !rdEmpty && waitCnt < 8);
      if (!rdValid && !rdEmpty) begin
         abortRun("No rdValid or rdEmpty after a read strobe");
      end
      gotEmpty = rdEmpty;
   endtask

   // Read until the model runs dry and once more on the empty buffer
   task automatic drainAll();
      logic gotEmpty;
      int misses;
      misses = 0;
      repeat (idle) stepCycle(6'b0);
      while (expQ.size() > 0) begin
         readOnce(gotEmpty);
         // Late records may still be on their way in
         if (gotEmpty) begin
            misses++;
            if (misses > 4) begin
               abortRun($sformatf("Buffer empty with %0d records still expected",
                  expQ.size()));
            end
         end
      end
      readOnce(gotEmpty);
      if (!gotEmpty) begin
         abortRun("Read on an empty buffer did not give rdEmpty");
      end
   endtask

   task automatic checkCounters();
      checkCnt("lostCount", lostCount, traceCntT'(expLost));
      checkCnt("dropCount", dropCount, traceCntT'(expDrop));
   endtask

   initial begin
      #(2 * 40 * totalCycles);
      $display("Watchdog expired, the run hung");
      $display("*** FAILED ***");
      $fatal(1, "watchdog");
   end

   initial begin
      int lostBefore;
      int dropBefore;
      void'($urandom(71777));
      rstN = 1'b0;
      traceEnable = 1'b1;
      swResetN = 1'b1;
      rdStrobe = 1'b0;
      cfgWrValid = 1'b0;
      c0TxRdValid = 1'b0;
      c1TxWrValid = 1'b0;
      c0RxRdValid = 1'b0;
      c1RxWrValid = 1'b0;
      cfgIndex = '0;
      cfgData = '0;
      c0TxVc = VA;
      c0TxReq = rdLineS;
      c0TxAddr = '0;
      c0TxMdata = '0;
      c1TxVc = VA;
      c1TxReq = wrLineI;
      c1TxAddr = '0;
      c1TxMdata = '0;
      c1TxData = '0;
      c0RxVc = VA;
      c0RxResp = rdResp;
      c0RxMdata = '0;
      c0RxData = '0;
      c1RxVc = VA;
      c1RxResp = wrResp;
      c1RxMdata = '0;
      repeat (16) @(posedge clk);
      rstN <= 1'b1;

      // Each kind alone
      for (int i = 0; i < 6; i++) begin
         stepCycle(6'b000001 << i);
         repeat (gap - 1) stepCycle(6'b0);
      end
      drainAll();
      checkCounters();

      // Overlapping random events in short bursts so nothing drops
      for (int b = 0; b < bursts; b++) begin
         repeat (burstLen) stepCycle(randomMask());
         drainAll();
         checkCounters();
      end

      // Tracing off
      lostBefore = expLost;
      @(posedge clk);
      traceEnable <= 1'b0;
      repeat (offLen) stepCycle(randomMask());
      stepCycle(6'b0);
      traceEnable <= 1'b1;
      drainAll();
      checkCnt("lostCount", lostCount, traceCntT'(lostBefore));
      checkCounters();

      // Overfill with no reads until the end
      dropBefore = expDrop;
      repeat (depth + fillExtra) stepCycle(6'b010000);
      drainAll();
      checkCnt("dropCount", dropCount, traceCntT'(dropBefore + fillExtra));
      checkCounters();

      // Software reset toggles
      for (int i = 0; i < nToggle; i++) begin
         stepCycle(6'b000001);
         repeat (gap - 1) stepCycle(6'b0);
      end
      drainAll();
      checkCounters();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire
